/* bench/tb_thread_ctrl.sv */
`timescale 1ns/1ps

module tb_thread_ctrl;

    import trd_types_pkg::*;
    import trd_cmd_pkg::*;

    localparam pc_t   BOOT_PC      = 32'h0001_0000;
    localparam int    RESET_CYCLES = 10;
    localparam int    SEED         = 16;
    localparam int    MAX_CASES    = 64;
    localparam int    MARGIN       = 20;            // Spare cycles past the last case
    localparam string CASES_FILE   = "bench/thread_cases.txt";

    // Column positions inside one line of the cases file
    localparam int F_CV  = 0;
    localparam int F_OP  = 1;
    localparam int F_ACT = 2;
    localparam int F_OBJ = 3;
    localparam int F_PC  = 4;
    localparam int F_ST  = 5;
    localparam int F_PW  = 6;
    localparam int F_PWT = 7;
    localparam int F_PWD = 8;
    localparam int F_EV  = 9;
    localparam int F_ER  = 10;
    localparam int F_EN  = 11;
    localparam int F_EI  = 12;
    localparam int F_EO  = 13;
    localparam int NF    = 14;

    logic      clk;
    logic      rst_n;
    logic      cmd_valid;
    cmd_op_e   cmd_op;
    trd_id_t   act_trd;
    trd_id_t   obj_trd;
    pc_t       cmd_pc;
    logic      pc_wr;
    trd_id_t   pc_wr_trd;
    pc_t       pc_wr_data;
    logic      stall;

    trd_id_t   cur_trd;
    pc_t       cur_pc;
    trd_id_t   new_trd;
    trd_mask_t valid_trd;
    trd_mask_t run_trd;
    logic      trd_full;
    logic      trd_of;
    logic      invalid_op;

    logic [31:0] case_mem [NF*MAX_CASES];
    logic        stall_used [MAX_CASES];   // Stall value each case was driven with
    int          case_idx    = -1;
    int          cycle_cnt   = 0;
    int          cycle_limit = 1000;         // Replaced once the case count is known

    // Reference state
    trd_id_t   model_cur;
    pc_t       model_pc [NUM_TRD];
    trd_mask_t model_valid;
    trd_mask_t model_run;

    thread_ctrl #(
        .START_PC (BOOT_PC)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .act_trd    (act_trd),
        .obj_trd    (obj_trd),
        .cmd_pc     (cmd_pc),
        .pc_wr      (pc_wr),
        .pc_wr_trd  (pc_wr_trd),
        .pc_wr_data (pc_wr_data),
        .stall      (stall),
        .cur_trd    (cur_trd),
        .cur_pc     (cur_pc),
        .new_trd    (new_trd),
        .valid_trd  (valid_trd),
        .run_trd    (run_trd),
        .trd_full   (trd_full),
        .trd_of     (trd_of),
        .invalid_op (invalid_op)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout: run did not end within %0d cycles", cycle_limit);
            $display("** FAIL **");
            $fatal(1, "Timeout");
        end
    end

    function automatic logic [31:0] field(input int c, input int f);
        return case_mem[c*NF + f];
    endfunction

    // First running slot after from, wrapping to from itself
    function automatic trd_id_t next_running(input trd_id_t from, input trd_mask_t run);
        trd_id_t pick;
        trd_id_t s;
        logic    found;
        pick  = from;
        found = 1'b0;
        for (int k = 1; k <= NUM_TRD; k++) begin
            s = trd_id_t'((from + k) % NUM_TRD);
            if (!found && run[s]) begin
                pick  = s;
                found = 1'b1;
            end
        end
        return pick;
    endfunction

    function automatic trd_id_t lowest_free(input trd_mask_t used);
        trd_id_t slot;
        logic    found;
        slot  = '0;
        found = 1'b0;
        for (int k = 0; k < NUM_TRD; k++) begin
            if (!found && !used[k]) begin
                slot  = trd_id_t'(k);
                found = 1'b1;
            end
        end
        return slot;
    endfunction

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Stopped at case %0d", case_idx);
    endtask

    task automatic check_id(input string name, input trd_id_t got, input trd_id_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mask(input string name, input trd_mask_t got, input trd_mask_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_pc(input string name, input pc_t got, input pc_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic drive_idle();
        cmd_valid <= 1'b0;
        pc_wr     <= 1'b0;
        stall     <= 1'b0;
    endtask

    task automatic apply_case(input int c, output logic st);
        logic [31:0] st_sel;
        st_sel = field(c, F_ST);
        if (st_sel == 32'd2) begin
            st = 1'($urandom % 2);                   // Free cycle, stall at random
        end else begin
            st = 1'(st_sel);
        end
        cmd_valid  <= 1'(field(c, F_CV));
        cmd_op     <= cmd_op_e'(2'(field(c, F_OP)));
        act_trd    <= trd_id_t'(field(c, F_ACT));
        obj_trd    <= trd_id_t'(field(c, F_OBJ));
        cmd_pc     <= pc_t'(field(c, F_PC));
        stall      <= st;
        pc_wr      <= 1'(field(c, F_PW));
        pc_wr_trd  <= trd_id_t'(field(c, F_PWT));
        pc_wr_data <= pc_t'(field(c, F_PWD));
    endtask

    // Advance the model over the edge that took case c
    task automatic model_step(input int c, input logic st);
        trd_id_t slot;
        if (!st) begin
            model_cur = next_running(model_cur, model_run);
        end
        if (field(c, F_PW) != 0) begin
            slot = trd_id_t'(field(c, F_PWT));
            if (model_valid[slot]) begin
                model_pc[slot] = pc_t'(field(c, F_PWD));
            end
        end
        // Applied after the write-back so a create on the same slot wins
        if (field(c, F_CV) != 0 && cmd_op_e'(2'(field(c, F_OP))) == CMD_CREATE
                && model_valid != '1) begin
            slot = lowest_free(model_valid);
            model_pc[slot] = pc_t'(field(c, F_PC));
        end
        model_valid = trd_mask_t'(field(c, F_EV));
        model_run   = trd_mask_t'(field(c, F_ER));
    endtask

    task automatic check_case(input int c);
        trd_mask_t exp_valid;
        exp_valid = trd_mask_t'(field(c, F_EV));
        check_mask("valid_trd", valid_trd, exp_valid);
        check_mask("run_trd", run_trd, trd_mask_t'(field(c, F_ER)));
        check_id("new_trd", new_trd, trd_id_t'(field(c, F_EN)));
        check_flag("invalid_op", invalid_op, 1'(field(c, F_EI)));
        check_flag("trd_of", trd_of, 1'(field(c, F_EO)));
        check_flag("trd_full", trd_full, &exp_valid);
        check_id("cur_trd", cur_trd, model_cur);
        check_pc("cur_pc", cur_pc, model_pc[model_cur]);
    endtask

    initial begin
        int n_cases;
        n_cases    = 0;
        rst_n      = 1'b0;
        cmd_valid  = 1'b0;
        cmd_op     = CMD_CREATE;
        act_trd    = '0;
        obj_trd    = '0;
        cmd_pc     = '0;
        pc_wr      = 1'b0;
        pc_wr_trd  = '0;
        pc_wr_data = '0;
        stall      = 1'b0;
        void'($urandom(SEED));

        $readmemh(CASES_FILE, case_mem);
        while (n_cases < MAX_CASES
                && (field(n_cases, F_CV) === 32'd0 || field(n_cases, F_CV) === 32'd1)) begin
            n_cases++;
        end
        if (n_cases == 0) begin
            $display("No test cases could be read from %s", CASES_FILE);
            abort_run();
        end
        cycle_limit = RESET_CYCLES + n_cases + MARGIN;

        model_cur   = '0;
        model_valid = 8'h01;
        model_run   = 8'h01;
        for (int k = 0; k < NUM_TRD; k++) begin
            model_pc[k] = (k == 0) ? BOOT_PC : '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_mask("valid_trd", valid_trd, 8'h01);
        check_mask("run_trd", run_trd, 8'h01);
        check_id("cur_trd", cur_trd, '0);
        check_id("new_trd", new_trd, '0);
        check_pc("cur_pc", cur_pc, BOOT_PC);
        check_flag("invalid_op", invalid_op, 1'b0);
        check_flag("trd_of", trd_of, 1'b0);

        @(posedge clk);
        apply_case(0, stall_used[0]);
        for (int c = 0; c < n_cases; c++) begin
            case_idx = c;
            @(posedge clk);                          // Case c is taken here
            if (c + 1 < n_cases) begin
                apply_case(c + 1, stall_used[c + 1]);
            end else begin
                drive_idle();
            end
            model_step(c, stall_used[c]);
            @(negedge clk);
            check_case(c);
            if (i_dut.i_assert.fail_cnt != 0) begin
                $display("An assertion inside thread_ctrl failed");
                abort_run();
            end
        end

        @(posedge clk);
        @(negedge clk);
        if (i_dut.i_assert.fail_cnt == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("An assertion inside thread_ctrl failed after the last case");
            $display("** FAIL **");
            $fatal(1, "Assertion failure");
        end
    end

endmodule

/* bench/thread_cases.txt */
// cv op act obj cmd_pc stall pc_wr pc_wr_trd pc_wr_data  exp: valid run new invalid_op trd_of
// op 0 create 1 kill 2 sleep 3 wake, stall 2 is random, cv f ends the list
1 0 0 0 00002000 0 0 0 00000000 03 03 1 0 0
1 0 0 0 00003000 0 0 0 00000000 07 07 2 0 0
1 0 1 0 00004000 0 0 0 00000000 0f 0f 3 0 0
1 0 1 0 00005000 0 0 0 00000000 1f 1f 4 0 0
1 0 2 0 00006000 0 0 0 00000000 3f 3f 5 0 0
1 0 0 0 00007000 0 0 0 00000000 7f 7f 6 0 0
1 0 3 0 00008000 0 1 7 dead0000 ff ff 7 0 0
1 0 0 0 00009000 0 0 0 00000000 ff ff 7 0 1
0 0 0 0 00000000 0 0 0 00000000 ff ff 7 0 0
1 1 2 3 00000000 0 0 0 00000000 ff ff 7 1 0
1 1 0 0 00000000 0 0 0 00000000 ff ff 7 1 0
1 2 5 4 00000000 0 0 0 00000000 ff ff 7 1 0
0 0 0 0 00000000 0 1 4 00004444 ff ff 7 0 0
1 2 1 4 00000000 0 0 0 00000000 ff ef 7 0 0
1 2 5 5 00000000 0 0 0 00000000 ff cf 7 0 0
1 3 5 4 00000000 0 0 0 00000000 ff cf 7 1 0
1 3 1 4 00000000 0 0 0 00000000 ff df 7 0 0
1 1 3 7 00000000 0 0 0 00000000 7f 5f 7 0 0
1 1 0 7 00000000 0 0 0 00000000 7f 5f 7 1 0
1 3 3 7 00000000 0 0 0 00000000 7f 5f 7 1 0
1 1 6 6 00000000 0 0 0 00000000 3f 1f 7 0 0
1 0 4 0 0000a000 0 0 0 00000000 7f 5f 6 0 0
1 3 2 5 00000000 0 0 0 00000000 7f 7f 6 0 0
1 2 0 0 00000000 0 0 0 00000000 7f 7e 6 0 0
1 1 1 4 00000000 0 0 0 00000000 6f 6e 6 0 0
1 3 0 0 00000000 0 0 0 00000000 6f 6f 6 0 0
0 0 0 0 00000000 1 0 0 00000000 6f 6f 6 0 0
0 0 0 0 00000000 1 1 5 55550000 6f 6f 6 0 0
0 0 0 0 00000000 0 0 0 00000000 6f 6f 6 0 0
0 0 0 0 00000000 2 0 0 00000000 6f 6f 6 0 0
0 0 0 0 00000000 2 1 6 66660000 6f 6f 6 0 0
1 2 6 6 00000000 2 0 0 00000000 6f 2f 6 0 0
0 0 0 0 00000000 2 0 0 00000000 6f 2f 6 0 0
1 3 6 6 00000000 2 0 0 00000000 6f 6f 6 0 0
0 0 0 0 00000000 2 1 2 22220000 6f 6f 6 0 0
1 2 0 1 00000000 2 0 0 00000000 6f 6d 6 0 0
0 0 0 0 00000000 2 1 4 0000bad0 6f 6d 6 0 0
1 3 0 1 00000000 0 0 0 00000000 6f 6f 6 0 0
1 0 5 0 0000b000 0 1 4 deadbeef 7f 7f 4 0 0
0 0 0 0 00000000 0 0 0 00000000 7f 7f 4 0 0
f 0 0 0 00000000 0 0 0 00000000 00 00 0 0 0

/* bench/thread_ctrl_assertions.sv */
`timescale 1ns/1ps

module thread_ctrl_assertions (
    input logic                      clk,
    input logic                      rst_n,
    input logic                      cmd_valid,
    input trd_cmd_pkg::cmd_op_e      cmd_op,
    input trd_types_pkg::trd_id_t    cur_trd,
    input trd_types_pkg::trd_mask_t  valid_trd,
    input logic                      trd_full,
    input logic                      trd_of,
    input logic                      invalid_op
);

    import trd_cmd_pkg::*;

    int fail_cnt = 0;  // Read by the testbench

    // Error pulses only ever follow a command
    a_invalid_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        invalid_op |-> $past(cmd_valid))
        else begin
            fail_cnt++;
            $error("invalid_op raised without a command in the cycle before");
        end

    a_of_after_cmd: assert property (@(posedge clk) disable iff (!rst_n)
        trd_of |-> $past(cmd_valid))
        else begin
            fail_cnt++;
            $error("trd_of raised without a command in the cycle before");
        end

    a_cur_valid: assert property (@(posedge clk) disable iff (!rst_n)
        valid_trd[cur_trd])
        else begin
            fail_cnt++;
            $error("cur_trd points at a free slot");
        end

    // A create while full only pulses the overflow flag
    a_full_create: assert property (@(posedge clk) disable iff (!rst_n)
        (cmd_valid && cmd_op == CMD_CREATE && trd_full) |=> (trd_of && $stable(valid_trd)))
        else begin
            fail_cnt++;
            $error("create while full did not pulse trd_of or changed valid_trd");
        end

endmodule

bind thread_ctrl thread_ctrl_assertions i_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_op     (cmd_op),
    .cur_trd    (cur_trd),
    .valid_trd  (valid_trd),
    .trd_full   (trd_full),
    .trd_of     (trd_of),
    .invalid_op (invalid_op)
);

/* build.f */
rtl/trd_types_pkg.sv
rtl/trd_cmd_pkg.sv
rtl/thread_csr.sv
rtl/trd_alloc.sv
rtl/trd_sched.sv
rtl/thread_ctrl.sv
bench/thread_ctrl_assertions.sv
bench/tb_thread_ctrl.sv

/* rtl/thread_csr.sv */
`timescale 1ns/1ps

module thread_csr #(
    parameter trd_types_pkg::pc_t    START_PC = '0,  // Boot pc, slot 0 only
    parameter trd_types_pkg::trd_id_t TRD_ID  = '0   // Index of this slot
) (
    input  logic                    clk,
    input  logic                    rst_n,

    input  logic                    cmd_valid,
    input  trd_cmd_pkg::cmd_op_e    cmd_op,
    input  trd_types_pkg::trd_id_t  act_trd,
    input  trd_types_pkg::trd_id_t  obj_trd,
    input  trd_types_pkg::pc_t      cmd_pc,

    input  trd_types_pkg::trd_id_t  create_trd,  // Slot picked by the allocator
    input  logic                    create_ok,

    input  logic                    pc_wr,
    input  trd_types_pkg::trd_id_t  pc_wr_trd,
    input  trd_types_pkg::pc_t      pc_wr_data,

    output logic                    valid,
    output logic                    running,
    output logic                    error,       // One-cycle refusal pulse
    output trd_types_pkg::pc_t      pc
);

    import trd_types_pkg::*;
    import trd_cmd_pkg::*;

    trd_state_e state;
    trd_state_e state_nxt;
    trd_id_t    parent;     // Thread that created this one

    logic       is_obj;     // Kill, sleep or wake aimed at this slot
    logic       related;    // Actor is this thread or its parent
    logic       root_kill;  // Slot 0 may never be released
    logic       allowed;
    logic       do_create;
    logic       do_op;
    logic       pc_hit;

    assign is_obj    = cmd_valid && (cmd_op != CMD_CREATE) && (obj_trd == TRD_ID);
    assign related   = (act_trd == TRD_ID) || (parent == act_trd);
    assign root_kill = (TRD_ID == trd_id_t'(0)) && (cmd_op == CMD_KILL);
    assign allowed   = (state != TRD_FREE) && related && !root_kill;

    assign do_create = create_ok && (create_trd == TRD_ID);
    assign do_op     = is_obj && allowed;

    // Write-backs to a free slot are dropped
    assign pc_hit    = pc_wr && (pc_wr_trd == TRD_ID) && (state != TRD_FREE);

    always_comb begin
        state_nxt = state;
        if (do_create) begin
            state_nxt = TRD_RUN;
        end else if (do_op) begin
            case (cmd_op)
                CMD_KILL:  state_nxt = TRD_FREE;
                CMD_SLEEP: state_nxt = TRD_SLEEP;
                CMD_WAKE:  state_nxt = TRD_RUN;
                default:   state_nxt = state;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= (TRD_ID == trd_id_t'(0)) ? TRD_RUN : TRD_FREE;  // Root is alive
            error <= 1'b0;
        end else begin
            state <= state_nxt;
            error <= is_obj && !allowed;
        end
    end

    // Root boots from START_PC as its own parent
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            parent <= '0;
            pc     <= (TRD_ID == trd_id_t'(0)) ? START_PC : '0;
        end else if (do_create) begin
            parent <= act_trd;
            pc     <= cmd_pc;                // Create beats a write-back
        end else if (pc_hit) begin
            pc     <= pc_wr_data;
        end
    end

    assign valid   = (state != TRD_FREE);
    assign running = (state == TRD_RUN);

endmodule

/* rtl/thread_ctrl.sv */
`timescale 1ns/1ps

module thread_ctrl #(
    parameter trd_types_pkg::pc_t START_PC = 32'h0000_1000  // Boot pc of the root thread
) (
    input  logic                      clk,
    input  logic                      rst_n,

    // Thread command
    input  logic                      cmd_valid,
    input  trd_cmd_pkg::cmd_op_e      cmd_op,
    input  trd_types_pkg::trd_id_t    act_trd,     // Issuing thread
    input  trd_types_pkg::trd_id_t    obj_trd,     // Target of kill, sleep, wake
    input  trd_types_pkg::pc_t        cmd_pc,      // Start pc for create

    // PC write-back
    input  logic                      pc_wr,
    input  trd_types_pkg::trd_id_t    pc_wr_trd,
    input  trd_types_pkg::pc_t        pc_wr_data,

    input  logic                      stall,

    output trd_types_pkg::trd_id_t    cur_trd,
    output trd_types_pkg::pc_t        cur_pc,
    output trd_types_pkg::trd_id_t    new_trd,
    output trd_types_pkg::trd_mask_t  valid_trd,
    output trd_types_pkg::trd_mask_t  run_trd,
    output logic                      trd_full,
    output logic                      trd_of,
    output logic                      invalid_op
);

    import trd_types_pkg::*;

    pc_t       trd_pc [NUM_TRD];  // Stored pc of every slot
    trd_mask_t csr_err;           // Refusal pulses per slot
    trd_id_t   create_trd;
    logic      create_ok;

    // Allocation works off the current valid mask
    trd_alloc i_alloc (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .valid_trd  (valid_trd),
        .create_trd (create_trd),
        .create_ok  (create_ok),
        .new_trd    (new_trd),
        .trd_of     (trd_of)
    );

    // Every slot sees the same command and decodes its own part
    for (genvar i = 0; i < NUM_TRD; i++) begin : g_csr
        thread_csr #(
            .START_PC (START_PC),
            .TRD_ID   (trd_id_t'(i))
        ) i_csr (
            .clk        (clk),
            .rst_n      (rst_n),
            .cmd_valid  (cmd_valid),
            .cmd_op     (cmd_op),
            .act_trd    (act_trd),
            .obj_trd    (obj_trd),
            .cmd_pc     (cmd_pc),
            .create_trd (create_trd),
            .create_ok  (create_ok),
            .pc_wr      (pc_wr),
            .pc_wr_trd  (pc_wr_trd),
            .pc_wr_data (pc_wr_data),
            .valid      (valid_trd[i]),
            .running    (run_trd[i]),
            .error      (csr_err[i]),
            .pc         (trd_pc[i])
        );
    end

    trd_sched i_sched (
        .clk     (clk),
        .rst_n   (rst_n),
        .stall   (stall),
        .run_trd (run_trd),
        .trd_pc  (trd_pc),
        .cur_trd (cur_trd),
        .cur_pc  (cur_pc)
    );

    assign trd_full   = &valid_trd;
    assign invalid_op = |csr_err;  // At most one slot is targeted per cycle

endmodule

/* rtl/trd_alloc.sv */
`timescale 1ns/1ps

module trd_alloc (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      cmd_valid,
    input  trd_cmd_pkg::cmd_op_e      cmd_op,
    input  trd_types_pkg::trd_mask_t  valid_trd,

    output trd_types_pkg::trd_id_t    create_trd,  // Lowest free slot
    output logic                      create_ok,
    output trd_types_pkg::trd_id_t    new_trd,     // Id of the last created thread
    output logic                      trd_of       // Create while full
);

    import trd_types_pkg::*;
    import trd_cmd_pkg::*;

    logic is_create;
    logic all_used;

    assign is_create = cmd_valid && (cmd_op == CMD_CREATE);
    assign all_used  = &valid_trd;

    // Scan from the top so the lowest free index wins
    always_comb begin
        create_trd = '0;
        for (int i = NUM_TRD - 1; i >= 0; i--) begin
            if (!valid_trd[i]) begin
                create_trd = trd_id_t'(i);
            end
        end
    end

    assign create_ok = is_create && !all_used;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            new_trd <= '0;
            trd_of  <= 1'b0;
        end else begin
            if (create_ok) begin
                new_trd <= create_trd;
            end
            trd_of <= is_create && all_used;  // Single-cycle pulse
        end
    end

endmodule

/* rtl/trd_cmd_pkg.sv */
package trd_cmd_pkg;

    // Thread commands, one per cycle when cmd_valid is high
    typedef enum logic [1:0] {
        CMD_CREATE = 2'b00,  // Start a child in the lowest free slot
        CMD_KILL   = 2'b01,  // Release the target slot
        CMD_SLEEP  = 2'b10,  // Park the target
        CMD_WAKE   = 2'b11   // Resume a parked target
    } cmd_op_e;

    // Create ignores obj_trd; the other three act on obj_trd
    // and go through the parent/self permission check

endpackage

/* rtl/trd_sched.sv */
`timescale 1ns/1ps

module trd_sched (
    input  logic                      clk,
    input  logic                      rst_n,

    input  logic                      stall,        // Freeze the pointer
    input  trd_types_pkg::trd_mask_t  run_trd,
    input  trd_types_pkg::pc_t        trd_pc [trd_types_pkg::NUM_TRD],

    output trd_types_pkg::trd_id_t    cur_trd,
    output trd_types_pkg::pc_t        cur_pc
);

    import trd_types_pkg::*;

    trd_mask_t run_rot;  // run_trd rotated so bit 0 is the slot after cur_trd
    trd_id_t   nxt_trd;

    // Bit i of run_rot is slot (cur_trd + 1 + i) mod NUM_TRD.
    // Bit 7 wraps back to cur_trd itself, so a lone runner keeps the pointer.
    assign run_rot = trd_mask_t'({run_trd, run_trd} >> (cur_trd + 4'd1));

    always_comb begin
        nxt_trd = cur_trd;                   // Nothing running, stay put
        for (int i = NUM_TRD - 1; i >= 0; i--) begin
            if (run_rot[i]) begin
                nxt_trd = cur_trd + trd_id_t'(i + 1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_trd <= '0;
        end else if (!stall) begin
            cur_trd <= nxt_trd;
        end
    end

    assign cur_pc = trd_pc[cur_trd];

endmodule

/* rtl/trd_types_pkg.sv */
package trd_types_pkg;

    // Slot count and field widths
    localparam int NUM_TRD  = 8;
    localparam int TRD_ID_W = 3;
    localparam int PC_W     = 32;

    // Index of one thread slot
    typedef logic [TRD_ID_W-1:0] trd_id_t;

    // One bit per slot, bit i belongs to slot i
    typedef logic [NUM_TRD-1:0] trd_mask_t;

    // Program counter as seen by the fetch stage
    typedef logic [PC_W-1:0] pc_t;

    // Life cycle of a slot
    //   FREE  -> RUN    on create
    //   RUN   -> SLEEP  on sleep
    //   SLEEP -> RUN    on wake
    //   any   -> FREE   on kill (never for slot 0)
    typedef enum logic [1:0] {
        TRD_FREE  = 2'b00,  // Slot unused, may be allocated
        TRD_RUN   = 2'b01,  // Eligible for issue
        TRD_SLEEP = 2'b10   // Allocated but skipped by the scheduler
    } trd_state_e;

endpackage
